// File: common/cpu16FwdIf.sv
`timescale 1ns/1ns
`default_nettype none

interface cpu16FwdIf import cpu16IsaPkg::*; ();

	// execute/memory register contents
	logic memRegWrite;
	regIdxT memDest;
	wordT memResult;

	// memory/write-back register contents
	logic wbRegWrite;
	regIdxT wbDest;
	wordT wbData;

	modport memSrc (output memRegWrite, memDest, memResult);

	// memory stage also needs the address and destination
	modport wbSrc (input memDest, memResult, output wbRegWrite, wbDest, wbData);

	modport sink (input memRegWrite, memDest, memResult, wbRegWrite, wbDest, wbData);

endinterface

`default_nettype wire

// File: common/cpu16IsaPkg.sv
`default_nettype none

`include "cpu16_config.svh"

package cpu16IsaPkg;

	typedef logic [`CPU16_XLEN-1:0] wordT;
	typedef logic [`CPU16_REG_ADDR_W-1:0] regIdxT;

	// ----------------------------------------------------------------------------
	// opcodes, bits 15..11 of the instruction word
	// ----------------------------------------------------------------------------
	typedef enum logic [4:0]
	{
		OP_NOP   = 5'b00001,
		OP_BEQZ  = 5'b00100,
		OP_ADDIU = 5'b01001,
		OP_LI    = 5'b01101,
		OP_LW    = 5'b10011,
		OP_SW    = 5'b11011,
		OP_SUBU  = 5'b11000,
		OP_ADDU  = 5'b11100,
		OP_JR    = 5'b11101,
		OP_AND   = 5'b11110,
		OP_OR    = 5'b11111
	} opcodeT;

	// field layout; immediates overlay the low bits
	typedef struct packed
	{
		opcodeT opcode;
		regIdxT rx;
		regIdxT ry;
		regIdxT rz;
		logic [1:0] func;
	} instrT;

	// bubble inserted by squash and reset
	localparam wordT INSTR_NOP = {OP_NOP, {(`CPU16_XLEN-5){1'b0}}};

endpackage

`default_nettype wire

// File: common/cpu16PipePkg.sv
`default_nettype none

package cpu16PipePkg;

	typedef enum logic [2:0]
	{
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_PASSB
	} aluOpT;

	// operand source in execute
	typedef enum logic [1:0]
	{
		FWD_REGFILE,
		FWD_FROM_MEM,
		FWD_FROM_WB
	} fwdSelT;

	// which field names the destination register
	typedef enum logic [1:0]
	{
		DST_RX,
		DST_RY,
		DST_RZ
	} dstSelT;

	// ----------------------------------------------------------------------------
	// decoded control, carried from decode through memory
	// ----------------------------------------------------------------------------
	typedef struct packed
	{
		aluOpT aluOp;
		logic src2Imm;
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic branch;
		logic jump;
		dstSelT dstSelect;
	} ctrlT;

endpackage

`default_nettype wire

// File: common/cpu16_config.svh
`ifndef CPU16_CONFIG_SVH
`define CPU16_CONFIG_SVH

// datapath and address width
`define CPU16_XLEN 16

// register index width and count
`define CPU16_REG_ADDR_W 3
`define CPU16_NUM_REGS 8

// first fetch address out of reset
`define CPU16_RESET_PC 16'h0000

`endif

// File: cpu16.f
+incdir+common
common/cpu16IsaPkg.sv
common/cpu16PipePkg.sv
common/cpu16FwdIf.sv
verilog/fetchUnit.sv
decode/registerFile.sv
decode/decodeStage.sv
verilog/executeStage.sv
verilog/memWbStage.sv
verilog/cpu16Top.sv
verif/cpu16_properties.sv
verif/cpu16Checker.sv
verif/cpu16Tb.sv

// File: decode/decodeStage.sv
`timescale 1ns/1ns
`default_nettype none

module decodeStage import cpu16IsaPkg::*; import cpu16PipePkg::*; (
	input logic CLK,
	input logic RST,
	input logic jumpTaken,
	input logic branchTaken,
	input wordT idInstr,
	input wordT idPcPlus,
	input wordT rdData1,
	input wordT rdData2,
	output regIdxT rdAddr1,
	output regIdxT rdAddr2,
	output logic stall,
	output ctrlT exCtrl,
	output wordT exPcPlus,
	output wordT exOp1,
	output wordT exOp2,
	output wordT exImm,
	output regIdxT exRx,
	output regIdxT exRy,
	output regIdxT exRz
);

	instrT inst;
	ctrlT ctrl;
	wordT imm;
	logic loadUse;
	logic bubble;

	assign inst = instrT'(idInstr);
	assign rdAddr1 = inst.rx;
	assign rdAddr2 = inst.ry;

	// ----------------------------------------------------------------------------
	// opcode to control
	// ----------------------------------------------------------------------------
	always_comb
	begin
		ctrl = '0;
		ctrl.aluOp = ALU_ADD;
		ctrl.dstSelect = DST_RZ;
		case (inst.opcode)
			OP_ADDU: ctrl.regWrite = 1'b1;
			OP_SUBU:
			begin
				ctrl.aluOp = ALU_SUB;
				ctrl.regWrite = 1'b1;
			end
			OP_AND:
			begin
				ctrl.aluOp = ALU_AND;
				ctrl.regWrite = 1'b1;
			end
			OP_OR:
			begin
				ctrl.aluOp = ALU_OR;
				ctrl.regWrite = 1'b1;
			end
			OP_ADDIU:
			begin
				ctrl.src2Imm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.dstSelect = DST_RX;
			end
			OP_LI:
			begin
				ctrl.aluOp = ALU_PASSB;
				ctrl.src2Imm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.dstSelect = DST_RX;
			end
			OP_LW:
			begin
				ctrl.src2Imm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.dstSelect = DST_RY;
			end
			// address is rx + imm, data is ry
			OP_SW:
			begin
				ctrl.src2Imm = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			OP_BEQZ: ctrl.branch = 1'b1;
			OP_JR: ctrl.jump = 1'b1;
			default: ctrl.regWrite = 1'b0;
		endcase
	end

	// imm8 zero-extended for LI only, imm5 for memory ops
	always_comb
	begin
		case (inst.opcode)
			OP_LI: imm = wordT'(idInstr[7:0]);
			OP_ADDIU, OP_BEQZ: imm = wordT'(signed'(idInstr[7:0]));
			OP_LW, OP_SW: imm = wordT'(signed'(idInstr[4:0]));
			default: imm = '0;
		endcase
	end

	// load in execute feeding rx or ry here
	assign loadUse = exCtrl.memRead && ((exRy == inst.rx) || (exRy == inst.ry));

	// a redirect squashes this instruction anyway, so no hold then
	assign stall = loadUse && !jumpTaken && !branchTaken;
	assign bubble = loadUse || jumpTaken || branchTaken;

	// ----------------------------------------------------------------------------
	// decode/execute register
	// ----------------------------------------------------------------------------
	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
			exCtrl <= '0;
		else
			exCtrl <= bubble ? ctrlT'('0) : ctrl;
	end

	always_ff @(posedge CLK)
	begin
		exPcPlus <= idPcPlus;
		exOp1 <= rdData1;
		exOp2 <= rdData2;
		exImm <= imm;
		exRx <= inst.rx;
		exRy <= inst.ry;
		exRz <= inst.rz;
	end

endmodule

`default_nettype wire

// File: decode/registerFile.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu16_config.svh"

module registerFile import cpu16IsaPkg::*; (
	input logic CLK,
	input logic RST,
	input regIdxT rdAddr1,
	input regIdxT rdAddr2,
	output wordT rdData1,
	output wordT rdData2,
	cpu16FwdIf.sink fwd
);

	wordT regs [`CPU16_NUM_REGS];

	// same-cycle write shows through on the read side
	function automatic wordT readPort(input regIdxT addr);
		if (fwd.wbRegWrite && (fwd.wbDest == addr))
			return fwd.wbData;
		return regs[addr];
	endfunction

	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
		begin
			for (int i = 0; i < `CPU16_NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (fwd.wbRegWrite)
			regs[fwd.wbDest] <= fwd.wbData;
	end

	always_comb
	begin
		rdData1 = readPort(rdAddr1);
		rdData2 = readPort(rdAddr2);
	end

endmodule

`default_nettype wire

// File: verif/cpu16Checker.sv
`timescale 1ns/1ns
`default_nettype none

module cpu16Checker import cpu16IsaPkg::*; (
	input logic CLK,
	input logic RST,
	input logic progReady,
	input wordT progMem [96],
	input wordT dataInit [256],
	input logic regWrValid,
	input regIdxT regWrAddr,
	input wordT regWrData,
	input logic dataWrEn,
	input wordT dataAddr,
	input wordT dataWrData,
	output logic done,
	output int valueErrors,
	output int extraErrors
);

	// expected events from the instruction-set model
	logic [18:0] regQ [$];
	logic [31:0] storeQ [$];
	logic built = 1'b0;
	int valCnt = 0;
	int extraCnt = 0;

	assign valueErrors = valCnt;
	assign extraErrors = extraCnt;

	function automatic wordT sext8(input wordT w);
		return {{8{w[7]}}, w[7:0]};
	endfunction

	function automatic wordT sext5(input wordT w);
		return {{11{w[4]}}, w[4:0]};
	endfunction

	// ------------------------------------------------------------------------
	// instruction-set model with one branch delay slot
	// ------------------------------------------------------------------------
	task automatic buildExpected();
		wordT regs [8];
		wordT mem [256];
		wordT pc;
		wordT nextPc;
		wordT pendTarget;
		wordT instr;
		wordT addr;
		logic pending;
		logic wasPending;
		int steps;
		regIdxT rx;
		regIdxT ry;
		regIdxT rz;
		for (int i = 0; i < 8; i++)
			regs[i] = '0;
		for (int i = 0; i < 256; i++)
			mem[i] = dataInit[i];
		pc = '0;
		pending = 1'b0;
		pendTarget = '0;
		steps = 0;
		while ((steps < 1000) && ((pc < 96) || pending))
		begin
			instr = (pc < 96) ? progMem[pc] : INSTR_NOP;
			rx = instr[10:8];
			ry = instr[7:5];
			rz = instr[4:2];
			nextPc = pc + 16'd1;
			wasPending = pending;
			pending = 1'b0;
			case (instr[15:11])
				OP_ADDU: regs[rz] = regs[rx] + regs[ry];
				OP_SUBU: regs[rz] = regs[rx] - regs[ry];
				OP_AND: regs[rz] = regs[rx] & regs[ry];
				OP_OR: regs[rz] = regs[rx] | regs[ry];
				OP_ADDIU: regs[rx] = regs[rx] + sext8(instr);
				OP_LI: regs[rx] = {8'h00, instr[7:0]};
				OP_LW:
				begin
					addr = regs[rx] + sext5(instr);
					regs[ry] = mem[addr[7:0]];
				end
				OP_SW:
				begin
					addr = regs[rx] + sext5(instr);
					mem[addr[7:0]] = regs[ry];
					storeQ.push_back({addr, regs[ry]});
				end
				OP_BEQZ:
				begin
					if (regs[rx] == '0)
					begin
						pending = 1'b1;
						pendTarget = pc + 16'd1 + sext8(instr);
					end
				end
				OP_JR: nextPc = regs[rx];
				default: ;
			endcase
			// retirement record for any register write
			case (instr[15:11])
				OP_ADDU, OP_SUBU, OP_AND, OP_OR: regQ.push_back({rz, regs[rz]});
				OP_ADDIU, OP_LI: regQ.push_back({rx, regs[rx]});
				OP_LW: regQ.push_back({ry, regs[ry]});
				default: ;
			endcase
			// the delay slot just ran
			if (wasPending)
				nextPc = pendTarget;
			pc = nextPc;
			steps++;
		end
	endtask

	initial
	begin
		wait (progReady);
		buildExpected();
		built = 1'b1;
	end

	// compare in mid-cycle where outputs are settled
	always @(negedge CLK)
	begin
		logic [18:0] expReg;
		logic [31:0] expStore;
		if (RST && regWrValid)
		begin
			if (regQ.size() == 0)
			begin
				extraCnt++;
				$display("unexpected register write to r%0d after the last retirement",
					regWrAddr);
			end
			else
			begin
				expReg = regQ.pop_front();
				if (regWrAddr !== expReg[18:16])
				begin
					valCnt++;
					$display("[ERROR] regWrAddr got %h expected %h", regWrAddr, expReg[18:16]);
				end
				if (regWrData !== expReg[15:0])
				begin
					valCnt++;
					$display("[ERROR] regWrData got %h expected %h", regWrData, expReg[15:0]);
				end
			end
		end
		if (RST && dataWrEn)
		begin
			if (storeQ.size() == 0)
			begin
				extraCnt++;
				$display("unexpected store to address %h after the last store", dataAddr);
			end
			else
			begin
				expStore = storeQ.pop_front();
				if (dataAddr !== expStore[31:16])
				begin
					valCnt++;
					$display("[ERROR] dataAddr got %h expected %h", dataAddr, expStore[31:16]);
				end
				if (dataWrData !== expStore[15:0])
				begin
					valCnt++;
					$display("[ERROR] dataWrData got %h expected %h", dataWrData,
						expStore[15:0]);
				end
			end
		end
		done = built && (regQ.size() == 0) && (storeQ.size() == 0);
	end

endmodule

`default_nettype wire

// File: verif/cpu16Tb.sv
`timescale 1ns/1ns
`default_nettype none

module cpu16Tb import cpu16IsaPkg::*; ();

	localparam int PROG_LEN = 96;
	localparam int TIMEOUT_CYCLES = 16 + PROG_LEN * 3 + 100;

	logic CLK;
	logic RST;
	wordT instrAddr;
	wordT instrData;
	wordT dataAddr;
	wordT dataWrData;
	logic dataWrEn;
	logic dataRdEn;
	wordT dataRdData;
	logic regWrValid;
	regIdxT regWrAddr;
	wordT regWrData;

	wordT progMem [PROG_LEN];
	wordT dataInit [256];
	wordT dataMem [256];
	logic progReady;
	logic checkDone;
	int valueErrors;
	int extraErrors;
	logic [31:0] lfsr;
	int idx;

	always #10 CLK = ~CLK;

	// combinational instruction and data memories
	assign instrData = (instrAddr < PROG_LEN) ? progMem[instrAddr] : INSTR_NOP;
	assign dataRdData = dataMem[dataAddr[7:0]];

	always @(posedge CLK)
	begin
		if (RST && dataWrEn)
			dataMem[dataAddr[7:0]] <= dataWrData;
	end

	// ------------------------------------------------------------------------
	// program generator
	// ------------------------------------------------------------------------
	// taps 32, 22, 2, 1
	function automatic logic [15:0] takeBits(input int n);
		logic [15:0] val;
		logic fb;
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			val = {val[14:0], fb};
		end
		return val;
	endfunction

	task automatic putInstr(input wordT w);
		if (idx < PROG_LEN)
			progMem[idx] = w;
		idx++;
	endtask

	function automatic wordT randomAlu();
		opcodeT op;
		case (takeBits(2))
			0: op = OP_ADDU;
			1: op = OP_SUBU;
			2: op = OP_AND;
			default: op = OP_OR;
		endcase
		return {op, 3'(takeBits(3)), 3'(takeBits(3)), 3'(takeBits(3)), 2'b00};
	endfunction

	// skipped instructions never hold a jump
	function automatic wordT randomFiller();
		if (takeBits(1))
			return {OP_ADDIU, 3'(takeBits(3)), 8'(takeBits(8))};
		return randomAlu();
	endfunction

	task automatic genProgram();
		regIdxT r;
		regIdxT ld;
		int off;
		for (int i = 0; i < PROG_LEN; i++)
			progMem[i] = INSTR_NOP;
		idx = 0;
		while (idx < 84)
		begin
			r = 3'(takeBits(3));
			case (takeBits(3))
				0, 1: putInstr(randomAlu());
				2: putInstr({OP_ADDIU, r, 8'(takeBits(8))});
				3: putInstr({OP_LI, r, 8'(takeBits(8))});
				4:
				begin
					ld = 3'(takeBits(3));
					putInstr({OP_LI, r, 8'(takeBits(8))});
					putInstr({OP_LW, r, ld, 5'(takeBits(5))});
					// immediate use of the loaded register
					if (takeBits(1))
						putInstr({OP_ADDU, ld, 3'(takeBits(3)), 3'(takeBits(3)), 2'b00});
				end
				5:
				begin
					putInstr({OP_LI, r, 8'(takeBits(8))});
					putInstr({OP_SW, r, 3'(takeBits(3)), 5'(takeBits(5))});
				end
				6:
				begin
					if (takeBits(1))
						putInstr({OP_LI, r, 8'h00});
					off = 2 + (takeBits(3) % 5);
					putInstr({OP_BEQZ, r, 8'(off)});
					putInstr(randomAlu());
					for (int k = 1; k < off; k++)
						putInstr(randomFiller());
				end
				default:
				begin
					off = 1 + takeBits(2);
					putInstr({OP_LI, r, 8'(idx + 2 + off)});
					putInstr({OP_JR, r, 8'h00});
					for (int k = 0; k < off; k++)
						putInstr(randomFiller());
				end
			endcase
		end
	endtask

	cpu16Top u_dut (
		.CLK(CLK), .RST(RST),
		.instrAddr(instrAddr), .instrData(instrData),
		.dataAddr(dataAddr), .dataWrData(dataWrData),
		.dataWrEn(dataWrEn), .dataRdEn(dataRdEn), .dataRdData(dataRdData),
		.regWrValid(regWrValid), .regWrAddr(regWrAddr), .regWrData(regWrData)
	);

	bind cpu16Top cpu16Properties u_props (.*);

	cpu16Checker u_check (
		.CLK(CLK), .RST(RST), .progReady(progReady),
		.progMem(progMem), .dataInit(dataInit),
		.regWrValid(regWrValid), .regWrAddr(regWrAddr), .regWrData(regWrData),
		.dataWrEn(dataWrEn), .dataAddr(dataAddr), .dataWrData(dataWrData),
		.done(checkDone), .valueErrors(valueErrors), .extraErrors(extraErrors)
	);

	initial
	begin
		CLK = 1'b0;
		RST = 1'b0;
		progReady = 1'b0;
		lfsr = 32'hf069_74ba;
		genProgram();
		for (int i = 0; i < 256; i++)
		begin
			dataInit[i] = takeBits(16);
			dataMem[i] = dataInit[i];
		end
		// released after the arrays have settled at the checker
		progReady <= 1'b1;
		repeat (16) @(posedge CLK);
		RST <= 1'b1;
		wait (checkDone === 1'b1);
		// catch any retirement beyond the model's last one
		repeat (10) @(posedge CLK);
		$display("errors: wrong values %0d, unexpected events %0d", valueErrors, extraErrors);
		if ((valueErrors == 0) && (extraErrors == 0))
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// watchdog
	initial
	begin
		#(TIMEOUT_CYCLES * 20);
		$display("timeout: expected retirements and stores did not all arrive in %0d cycles",
			TIMEOUT_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/cpu16_properties.sv
`timescale 1ns/1ns
`default_nettype none

module cpu16Properties import cpu16IsaPkg::*; (
	input logic CLK,
	input logic RST,
	input wordT instrAddr,
	input logic dataWrEn,
	input logic dataRdEn,
	input logic regWrValid
);

	// one data strobe at a time
	strobeExclusive: assert property (@(posedge CLK) disable iff (!RST)
		!(dataWrEn && dataRdEn))
		else $error("data read and write strobes high together");

	// quiet outputs and pc at the reset address while in reset
	resetQuiet: assert property (@(posedge CLK)
		(!RST) [*2] |-> (instrAddr == 16'h0000) && !regWrValid && !dataWrEn && !dataRdEn)
		else $error("outputs active or pc moved during reset");

	// first fetch after release comes from address 0
	firstFetch: assert property (@(posedge CLK) $rose(RST) |-> (instrAddr == 16'h0000))
		else $error("first fetch address is not zero");

	// nothing can reach the data port or write-back this early
	pipeFill: assert property (@(posedge CLK)
		$rose(RST) |-> (!regWrValid && !dataWrEn && !dataRdEn) [*3])
		else $error("retirement or data access before the pipeline filled");

	knownValid: assert property (@(posedge CLK) disable iff (!RST)
		!$isunknown({regWrValid, dataWrEn, dataRdEn}))
		else $error("unknown value on a strobe");

endmodule

`default_nettype wire

// File: verilog/cpu16Top.sv
`timescale 1ns/1ns
`default_nettype none

module cpu16Top import cpu16IsaPkg::*; import cpu16PipePkg::*; (
	input logic CLK,
	input logic RST,
	output wordT instrAddr,
	input wordT instrData,
	output wordT dataAddr,
	output wordT dataWrData,
	output logic dataWrEn,
	output logic dataRdEn,
	input wordT dataRdData,
	output logic regWrValid,
	output regIdxT regWrAddr,
	output wordT regWrData
);

	// redirect and hold
	logic stall;
	logic jumpTaken;
	logic branchTaken;
	wordT jumpTarget;
	wordT branchTarget;

	// fetch/decode
	wordT idInstr;
	wordT idPcPlus;

	// register file ports
	regIdxT rdAddr1;
	regIdxT rdAddr2;
	wordT rdData1;
	wordT rdData2;

	// decode/execute
	ctrlT exCtrl;
	wordT exPcPlus;
	wordT exOp1;
	wordT exOp2;
	wordT exImm;
	regIdxT exRx;
	regIdxT exRy;
	regIdxT exRz;

	// execute/memory
	ctrlT memCtrl;
	logic memZero;
	wordT memBranchTarget;
	wordT memStoreData;

	cpu16FwdIf fwdBus ();

	fetchUnit u_fetch (
		.CLK(CLK), .RST(RST), .stall(stall),
		.jumpTaken(jumpTaken), .branchTaken(branchTaken),
		.jumpTarget(jumpTarget), .branchTarget(branchTarget),
		.instrData(instrData), .instrAddr(instrAddr),
		.idInstr(idInstr), .idPcPlus(idPcPlus)
	);

	decodeStage u_decode (
		.CLK(CLK), .RST(RST), .jumpTaken(jumpTaken), .branchTaken(branchTaken),
		.idInstr(idInstr), .idPcPlus(idPcPlus),
		.rdData1(rdData1), .rdData2(rdData2), .rdAddr1(rdAddr1), .rdAddr2(rdAddr2),
		.stall(stall), .exCtrl(exCtrl), .exPcPlus(exPcPlus),
		.exOp1(exOp1), .exOp2(exOp2), .exImm(exImm),
		.exRx(exRx), .exRy(exRy), .exRz(exRz)
	);

	registerFile u_regs (
		.CLK(CLK), .RST(RST),
		.rdAddr1(rdAddr1), .rdAddr2(rdAddr2),
		.rdData1(rdData1), .rdData2(rdData2),
		.fwd(fwdBus)
	);

	executeStage u_execute (
		.CLK(CLK), .RST(RST), .exCtrl(exCtrl), .exPcPlus(exPcPlus),
		.exOp1(exOp1), .exOp2(exOp2), .exImm(exImm),
		.exRx(exRx), .exRy(exRy), .exRz(exRz),
		.fwd(fwdBus), .fwdRd(fwdBus),
		.jumpTaken(jumpTaken), .jumpTarget(jumpTarget),
		.memCtrl(memCtrl), .memZero(memZero),
		.memBranchTarget(memBranchTarget), .memStoreData(memStoreData)
	);

	memWbStage u_memWb (
		.CLK(CLK), .RST(RST), .memCtrl(memCtrl), .memZero(memZero),
		.memBranchTarget(memBranchTarget), .memStoreData(memStoreData),
		.fwd(fwdBus), .branchTaken(branchTaken), .branchTarget(branchTarget),
		.dataAddr(dataAddr), .dataWrData(dataWrData),
		.dataWrEn(dataWrEn), .dataRdEn(dataRdEn), .dataRdData(dataRdData),
		.regWrValid(regWrValid), .regWrAddr(regWrAddr), .regWrData(regWrData)
	);

endmodule

`default_nettype wire

// File: verilog/executeStage.sv
`timescale 1ns/1ns
`default_nettype none

module executeStage import cpu16IsaPkg::*; import cpu16PipePkg::*; (
	input logic CLK,
	input logic RST,
	input ctrlT exCtrl,
	input wordT exPcPlus,
	input wordT exOp1,
	input wordT exOp2,
	input wordT exImm,
	input regIdxT exRx,
	input regIdxT exRy,
	input regIdxT exRz,
	cpu16FwdIf.memSrc fwd,
	cpu16FwdIf.sink fwdRd,
	output logic jumpTaken,
	output wordT jumpTarget,
	output ctrlT memCtrl,
	output logic memZero,
	output wordT memBranchTarget,
	output wordT memStoreData
);

	fwdSelT sel1;
	fwdSelT sel2;
	wordT op1;
	wordT op2;
	wordT aluB;
	wordT aluRes;
	regIdxT dest;
	wordT memResultQ;
	regIdxT memDestQ;

	// younger producer wins
	function automatic fwdSelT pickSrc(input regIdxT src);
		if (fwdRd.memRegWrite && (fwdRd.memDest == src))
			return FWD_FROM_MEM;
		if (fwdRd.wbRegWrite && (fwdRd.wbDest == src))
			return FWD_FROM_WB;
		return FWD_REGFILE;
	endfunction

	function automatic wordT pickOperand(input fwdSelT sel, input wordT regVal);
		case (sel)
			FWD_FROM_MEM: return fwdRd.memResult;
			FWD_FROM_WB: return fwdRd.wbData;
			default: return regVal;
		endcase
	endfunction

	always_comb
	begin
		sel1 = pickSrc(exRx);
		sel2 = pickSrc(exRy);
		op1 = pickOperand(sel1, exOp1);
		op2 = pickOperand(sel2, exOp2);
	end

	// ----------------------------------------------------------------------------
	// ALU
	// ----------------------------------------------------------------------------
	assign aluB = exCtrl.src2Imm ? exImm : op2;

	always_comb
	begin
		case (exCtrl.aluOp)
			ALU_ADD: aluRes = op1 + aluB;
			ALU_SUB: aluRes = op1 - aluB;
			ALU_AND: aluRes = op1 & aluB;
			ALU_OR: aluRes = op1 | aluB;
			ALU_PASSB: aluRes = aluB;
			default: aluRes = '0;
		endcase
	end

	always_comb
	begin
		case (exCtrl.dstSelect)
			DST_RX: dest = exRx;
			DST_RY: dest = exRy;
			default: dest = exRz;
		endcase
	end

	// JR resolves here on the forwarded rx
	assign jumpTaken = exCtrl.jump;
	assign jumpTarget = op1;

	// ----------------------------------------------------------------------------
	// execute/memory register
	// ----------------------------------------------------------------------------
	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
			memCtrl <= '0;
		else
			memCtrl <= exCtrl;
	end

	always_ff @(posedge CLK)
	begin
		memResultQ <= aluRes;
		memDestQ <= dest;
		// BEQZ tests rx
		memZero <= (op1 == '0);
		memBranchTarget <= exPcPlus + exImm;
		memStoreData <= op2;
	end

	assign fwd.memRegWrite = memCtrl.regWrite;
	assign fwd.memDest = memDestQ;
	assign fwd.memResult = memResultQ;

endmodule

`default_nettype wire

// File: verilog/fetchUnit.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu16_config.svh"

module fetchUnit import cpu16IsaPkg::*; (
	input logic CLK,
	input logic RST,
	input logic stall,
	input logic jumpTaken,
	input logic branchTaken,
	input wordT jumpTarget,
	input wordT branchTarget,
	input wordT instrData,
	output wordT instrAddr,
	output wordT idInstr,
	output wordT idPcPlus
);

	wordT pc;
	wordT pcPlus;

	assign instrAddr = pc;
	assign pcPlus = pc + wordT'(1);

	// hold beats jump, jump beats branch
	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
			pc <= `CPU16_RESET_PC;
		else if (!stall)
		begin
			if (jumpTaken)
				pc <= jumpTarget;
			else if (branchTaken)
				pc <= branchTarget;
			else
				pc <= pcPlus;
		end
	end

	// ----------------------------------------------------------------------------
	// fetch/decode register
	// ----------------------------------------------------------------------------
	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
			idInstr <= INSTR_NOP;
		else if (!stall)
			idInstr <= (jumpTaken || branchTaken) ? INSTR_NOP : instrData;
	end

	// pc + 1 feeds the branch target adder
	always_ff @(posedge CLK)
	begin
		if (!stall)
			idPcPlus <= pcPlus;
	end

endmodule

`default_nettype wire

// File: verilog/memWbStage.sv
`timescale 1ns/1ns
`default_nettype none

module memWbStage import cpu16IsaPkg::*; import cpu16PipePkg::*; (
	input logic CLK,
	input logic RST,
	input ctrlT memCtrl,
	input logic memZero,
	input wordT memBranchTarget,
	input wordT memStoreData,
	cpu16FwdIf.wbSrc fwd,
	output logic branchTaken,
	output wordT branchTarget,
	output wordT dataAddr,
	output wordT dataWrData,
	output logic dataWrEn,
	output logic dataRdEn,
	input wordT dataRdData,
	output logic regWrValid,
	output regIdxT regWrAddr,
	output wordT regWrData
);

	logic wbRegWrite;
	logic wbMemToReg;
	regIdxT wbDest;
	wordT wbLoad;
	wordT wbAlu;
	wordT wbData;

	// data port, combinational
	assign dataAddr = fwd.memResult;
	assign dataWrData = memStoreData;
	assign dataWrEn = memCtrl.memWrite;
	assign dataRdEn = memCtrl.memRead;

	// the instruction now in execute is the delay slot
	assign branchTaken = memCtrl.branch && memZero;
	assign branchTarget = memBranchTarget;

	// ----------------------------------------------------------------------------
	// memory/write-back register
	// ----------------------------------------------------------------------------
	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
		begin
			wbRegWrite <= 1'b0;
			wbMemToReg <= 1'b0;
		end
		else
		begin
			wbRegWrite <= memCtrl.regWrite;
			wbMemToReg <= memCtrl.memToReg;
		end
	end

	always_ff @(posedge CLK)
	begin
		wbDest <= fwd.memDest;
		wbLoad <= dataRdData;
		wbAlu <= fwd.memResult;
	end

	assign wbData = wbMemToReg ? wbLoad : wbAlu;

	assign fwd.wbRegWrite = wbRegWrite;
	assign fwd.wbDest = wbDest;
	assign fwd.wbData = wbData;

	// retirement
	assign regWrValid = wbRegWrite;
	assign regWrAddr = wbDest;
	assign regWrData = wbData;

endmodule

`default_nettype wire
